//--- hdl/mmio_pkg.sv
// Register map, APB and FIFO structs, config and status types, op enum, byte swap
package mmio_pkg;

	// ****************************************
	// Bus and register map
	// ****************************************

	localparam int addr_w = 8;

	localparam logic [addr_w-1:0] reg_cmd      = 8'h00;
	localparam logic [addr_w-1:0] reg_status   = 8'h04;
	localparam logic [addr_w-1:0] reg_config   = 8'h08;
	localparam logic [addr_w-1:0] reg_tx_data  = 8'h0C;
	localparam logic [addr_w-1:0] reg_tx_count = 8'h10;
	localparam logic [addr_w-1:0] reg_rx_data  = 8'h14;
	localparam logic [addr_w-1:0] reg_rx_count = 8'h18;

	typedef struct packed {
		logic              psel;
		logic              penable;
		logic              pwrite;
		logic [addr_w-1:0] paddr;
		logic [31:0]       pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic        pready;
		logic        pslverr;
	} apb_rsp_t;

	// ****************************************
	// Engine configuration and status
	// ****************************************

	typedef enum logic [1:0] {
		op_pass,
		op_swap,
		op_invert,
		op_add_key
	} xform_op_e;

	// Op sits in config bits 1:0, key in bits 7:2
	typedef struct packed {
		logic [5:0] key;
		xform_op_e  op;
	} cfg_t;

	typedef struct packed {
		logic [2:0] done_count;
		logic       done;
		logic       busy;
	} status_t;

	typedef struct packed {
		logic        push;
		logic [31:0] wdata;
	} fifo_wr_t;

	// Reverse the four bytes of a word
	function automatic logic [31:0] byte_swap(input logic [31:0] w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

endpackage

//--- hdl/word_fifo.sv
// Show-ahead synchronous FIFO of 32-bit words with fill count
`timescale 1ns/1ps

module word_fifo
	import mmio_pkg::*;
#(
	parameter int fifo_depth = 16,
	parameter int count_w = 5
)
(
	input  logic               rvx_port_30,
	input  logic               rvx_port_06,
	input  fifo_wr_t           wr,
	input  logic               pop,
	output logic [31:0]        rdata,
	output logic               full,
	output logic               empty,
	output logic [count_w-1:0] count
);

	localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;

	logic [31:0]        mem [fifo_depth];
	logic [ptr_w-1:0]   rd_ptr;
	logic [ptr_w-1:0]   wr_ptr;
	logic [count_w-1:0] occ;
	logic               do_push;
	logic               do_pop;

	// Pointer advance with wrap at the last slot
	function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
		return (p == ptr_w'(fifo_depth - 1)) ? '0 : p + 1'b1;
	endfunction

	assign full    = (occ == count_w'(fifo_depth));
	assign empty   = (occ == '0);
	assign count   = occ;
	// Head word is visible without a pop
	assign rdata   = mem[rd_ptr];
	assign do_push = wr.push && !full;
	assign do_pop  = pop && !empty;

	always_ff @(posedge rvx_port_30)
	begin
		if (do_push)
		begin
			mem[wr_ptr] <= wr.wdata;
		end
	end

	always_ff @(posedge rvx_port_30 or negedge rvx_port_06)
	begin
		if (!rvx_port_06)
		begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			occ    <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (do_pop)
				rd_ptr <= ptr_inc(rd_ptr);
			case ({do_push, do_pop})
				2'b10: occ <= occ + 1'b1;
				2'b01: occ <= occ - 1'b1;
				default: occ <= occ;
			endcase
		end
	end

	// Both sides of the FIFO must honour the flags
	a_no_push_full: assert property (@(posedge rvx_port_30) disable iff (!rvx_port_06)
		wr.push |-> !full)
		else $error("word_fifo: push while full");

	a_no_pop_empty: assert property (@(posedge rvx_port_30) disable iff (!rvx_port_06)
		pop |-> !empty)
		else $error("word_fifo: pop while empty");

endmodule

//--- hdl/apb_mmio_regs.sv
// APB register decoder with config register, start handshake, error response, byte order
`timescale 1ns/1ps

module apb_mmio_regs
	import mmio_pkg::*;
#(
	parameter bit big_endian = 1'b0,
	parameter int count_w = 5
)
(
	input  logic               rvx_port_30,
	input  logic               rvx_port_06,
	input  apb_req_t           apb_req,
	output apb_rsp_t           apb_rsp,
	output fifo_wr_t           tx_wr,
	input  logic               tx_full,
	input  logic [count_w-1:0] tx_count,
	output logic               rx_pop,
	input  logic [31:0]        rx_rdata,
	input  logic               rx_empty,
	input  logic [count_w-1:0] rx_count,
	output cfg_t               cfg,
	output logic               start_req,
	input  logic               start_ack,
	input  status_t            status
);

	logic              access;
	logic              aligned;
	logic [addr_w-1:0] word_addr;
	logic [31:0]       wdata;
	logic [31:0]       rdata_raw;
	logic              err;
	logic              tx_push;
	logic              cfg_we;
	logic              start_set;
	logic              cmd_blocked;

	// ****************************************
	// Access qualification
	// ****************************************

	assign access    = apb_req.psel && apb_req.penable;
	assign aligned   = (apb_req.paddr[1:0] == 2'b00);
	assign word_addr = {apb_req.paddr[addr_w-1:2], 2'b00};
	assign wdata     = big_endian ? byte_swap(apb_req.pwdata) : apb_req.pwdata;

	// A job is in flight from start write until the engine is idle again
	assign cmd_blocked = start_req || status.busy;

	always_comb
	begin
		rdata_raw = '0;
		err       = 1'b0;
		tx_push   = 1'b0;
		rx_pop    = 1'b0;
		cfg_we    = 1'b0;
		start_set = 1'b0;
		if (access)
		begin
			if (!aligned)
				err = 1'b1;
			else
			begin
				case (word_addr)
					reg_cmd:
					begin
						if (apb_req.pwrite)
						begin
							if (cmd_blocked)
								err = 1'b1;
							else
								start_set = wdata[0];
						end
					end
					reg_status:
					begin
						err = apb_req.pwrite;
						rdata_raw[$bits(status_t)-1:0] = status;
					end
					reg_config:
					begin
						cfg_we = apb_req.pwrite;
						rdata_raw[$bits(cfg_t)-1:0] = cfg;
					end
					reg_tx_data:
					begin
						// Write pushes, read returns the fill count
						if (apb_req.pwrite)
						begin
							if (tx_full)
								err = 1'b1;
							else
								tx_push = 1'b1;
						end
						rdata_raw[count_w-1:0] = tx_count;
					end
					reg_tx_count:
					begin
						err = apb_req.pwrite;
						rdata_raw[count_w-1:0] = tx_count;
					end
					reg_rx_data:
					begin
						if (apb_req.pwrite || rx_empty)
							err = 1'b1;
						else
							rx_pop = 1'b1;
						rdata_raw = rx_rdata;
					end
					reg_rx_count:
					begin
						err = apb_req.pwrite;
						rdata_raw[count_w-1:0] = rx_count;
					end
					default:
						err = 1'b1;
				endcase
			end
		end
	end

	assign apb_rsp = '{
		prdata:  big_endian ? byte_swap(rdata_raw) : rdata_raw,
		pready:  1'b1,
		pslverr: err
	};

	assign tx_wr = '{push: tx_push, wdata: wdata};

	// ****************************************
	// Config register and start handshake
	// ****************************************

	always_ff @(posedge rvx_port_30 or negedge rvx_port_06)
	begin
		if (!rvx_port_06)
		begin
			cfg       <= '0;
			start_req <= 1'b0;
		end
		else
		begin
			if (cfg_we)
				cfg <= cfg_t'(wdata[$bits(cfg_t)-1:0]);
			// Hold the request until the engine acknowledges
			if (start_req && start_ack)
				start_req <= 1'b0;
			else if (start_set)
				start_req <= 1'b1;
		end
	end

	// The engine may only acknowledge a pending request
	a_ack_needs_req: assert property (@(posedge rvx_port_30) disable iff (!rvx_port_06)
		$rose(start_ack) |-> start_req)
		else $error("apb_mmio_regs: start_ack raised without start_req");

endmodule

//--- hdl/transform_engine.sv
// Transform engine FSM moving words from transmit FIFO to receive FIFO
`timescale 1ns/1ps

module transform_engine
	import mmio_pkg::*;
(
	input  logic        rvx_port_30,
	input  logic        rvx_port_06,
	input  cfg_t        cfg,
	input  logic        start_req,
	output logic        start_ack,
	output logic        in_pop,
	input  logic [31:0] in_rdata,
	input  logic        in_empty,
	output fifo_wr_t    out_wr,
	input  logic        out_full,
	output status_t     status
);

	typedef enum logic [1:0] {
		st_idle,
		st_run,
		st_ack
	} state_e;

	state_e      state;
	logic        move;
	logic [31:0] result;
	logic [2:0]  done_count;
	logic        done;

	// One word per cycle while input has data and output has room
	assign move = (state == st_run) && !in_empty && !out_full;

	always_comb
	begin
		case (cfg.op)
			op_swap:    result = byte_swap(in_rdata);
			op_invert:  result = ~in_rdata;
			op_add_key: result = in_rdata + 32'(cfg.key);
			default:    result = in_rdata;
		endcase
	end

	assign in_pop = move;
	assign out_wr = '{push: move, wdata: result};

	assign status = '{
		done_count: done_count,
		done:       done,
		busy:       (state != st_idle)
	};

	// ****************************************
	// Control FSM
	// ****************************************

	always_ff @(posedge rvx_port_30 or negedge rvx_port_06)
	begin
		if (!rvx_port_06)
		begin
			state      <= st_idle;
			start_ack  <= 1'b0;
			done_count <= '0;
			done       <= 1'b0;
		end
		else
		begin
			case (state)
				st_idle:
				begin
					if (start_req)
					begin
						state      <= st_run;
						done_count <= '0;
						done       <= 1'b0;
					end
				end
				st_run:
				begin
					if (move)
						done_count <= done_count + 1'b1;
					else if (in_empty)
					begin
						// Drained, so finish and acknowledge the start
						state     <= st_ack;
						start_ack <= 1'b1;
						done      <= 1'b1;
					end
				end
				st_ack:
				begin
					if (!start_req)
					begin
						state     <= st_idle;
						start_ack <= 1'b0;
					end
				end
				default:
					state <= st_idle;
			endcase
		end
	end

	// Requester holds start_req until the acknowledge
	a_req_until_ack: assert property (@(posedge rvx_port_30) disable iff (!rvx_port_06)
		$fell(start_req) |-> $past(start_ack))
		else $error("transform_engine: start_req dropped before start_ack");

endmodule

//--- hdl/accel_top.sv
// Accelerator top level with register block, transmit and receive FIFOs and engine
`timescale 1ns/1ps

module accel_top
	import mmio_pkg::*;
#(
	parameter int fifo_depth = 16,
	parameter int count_w = $clog2(fifo_depth) + 1,
	parameter bit big_endian = 1'b0
)
(
	input  logic     rvx_port_30,
	input  logic     rvx_port_06,
	input  apb_req_t apb_req,
	output apb_rsp_t apb_rsp
);

	fifo_wr_t           tx_wr;
	logic               tx_full;
	logic               tx_empty;
	logic [count_w-1:0] tx_count;
	logic [31:0]        tx_rdata;
	logic               tx_pop;
	fifo_wr_t           rx_wr;
	logic               rx_full;
	logic               rx_empty;
	logic [count_w-1:0] rx_count;
	logic [31:0]        rx_rdata;
	logic               rx_pop;
	cfg_t               cfg;
	status_t            status;
	logic               start_req;
	logic               start_ack;

	apb_mmio_regs #(
		.big_endian (big_endian),
		.count_w    (count_w)
	) u_regs (
		.rvx_port_30 (rvx_port_30),
		.rvx_port_06 (rvx_port_06),
		.apb_req     (apb_req),
		.apb_rsp     (apb_rsp),
		.tx_wr       (tx_wr),
		.tx_full     (tx_full),
		.tx_count    (tx_count),
		.rx_pop      (rx_pop),
		.rx_rdata    (rx_rdata),
		.rx_empty    (rx_empty),
		.rx_count    (rx_count),
		.cfg         (cfg),
		.start_req   (start_req),
		.start_ack   (start_ack),
		.status      (status)
	);

	// Bus writes in, engine reads out
	word_fifo #(
		.fifo_depth (fifo_depth),
		.count_w    (count_w)
	) u_tx_fifo (
		.rvx_port_30 (rvx_port_30),
		.rvx_port_06 (rvx_port_06),
		.wr          (tx_wr),
		.pop         (tx_pop),
		.rdata       (tx_rdata),
		.full        (tx_full),
		.empty       (tx_empty),
		.count       (tx_count)
	);

	// Engine writes in, bus reads out
	word_fifo #(
		.fifo_depth (fifo_depth),
		.count_w    (count_w)
	) u_rx_fifo (
		.rvx_port_30 (rvx_port_30),
		.rvx_port_06 (rvx_port_06),
		.wr          (rx_wr),
		.pop         (rx_pop),
		.rdata       (rx_rdata),
		.full        (rx_full),
		.empty       (rx_empty),
		.count       (rx_count)
	);

	transform_engine u_engine (
		.rvx_port_30 (rvx_port_30),
		.rvx_port_06 (rvx_port_06),
		.cfg         (cfg),
		.start_req   (start_req),
		.start_ack   (start_ack),
		.in_pop      (tx_pop),
		.in_rdata    (tx_rdata),
		.in_empty    (tx_empty),
		.out_wr      (rx_wr),
		.out_full    (rx_full),
		.status      (status)
	);

endmodule

//--- bench/tb_accel_top.sv
// Testbench for the accelerator top level, driven by APB operations from a stimulus file
`timescale 1ns/1ps

module tb_accel_top
	import mmio_pkg::*;
();

	// ****************************************
	// Parameters and signals
	// ****************************************

	localparam int fifo_depth = 4;
	localparam int count_w    = 3;
	localparam int poll_cap   = 100;
	// About 60 lines at 3 cycles each plus six polls of up to 300 cycles
	localparam int max_cycles = 2000;

	logic     rvx_port_30;
	logic     rvx_port_06;
	apb_req_t apb_req;
	apb_rsp_t apb_rsp;

	int cycles = 0;
	int errors = 0;
	int checks = 0;

	accel_top #(
		.fifo_depth (fifo_depth),
		.count_w    (count_w),
		.big_endian (1'b0)
	) DUT (
		.rvx_port_30 (rvx_port_30),
		.rvx_port_06 (rvx_port_06),
		.apb_req     (apb_req),
		.apb_rsp     (apb_rsp)
	);

	initial
	begin
		rvx_port_30 = 1'b0;
		forever
			#4 rvx_port_30 = ~rvx_port_30;
	end

	// Run limit
	always @(posedge rvx_port_30)
	begin
		cycles <= cycles + 1;
		if (cycles >= max_cycles)
		begin
			$display("Timeout after %0d cycles, the run did not complete", cycles);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	// ****************************************
	// APB transfer and status poll
	// ****************************************

	// Setup cycle, access cycle, then back to idle
	task automatic apb_transfer(input logic write, input logic [7:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic slverr);
		@(posedge rvx_port_30);
		#1;
		apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
		@(posedge rvx_port_30);
		#1;
		apb_req.penable = 1'b1;
		// Response is combinational in the access phase
		@(negedge rvx_port_30);
		rdata  = apb_rsp.prdata;
		slverr = apb_rsp.pslverr;
		// Zero wait states, so pready is high in every access phase
		checks++;
		if (apb_rsp.pready !== 1'b1)
		begin
			$display("Error: pready at %h got %h expected %h", addr, apb_rsp.pready, 1'b1);
			errors++;
		end
		@(posedge rvx_port_30);
		#1;
		apb_req = '0;
	endtask

	// Read status until done is set and the engine is idle again
	task automatic poll_status(input logic [7:0] addr, output logic [31:0] st,
		output logic slverr, output logic found);
		int tries;
		found = 1'b0;
		tries = 0;
		st = '0;
		slverr = 1'b0;
		while (!found && tries < poll_cap)
		begin
			apb_transfer(1'b0, addr, 32'h0, st, slverr);
			tries++;
			if (st[1] && !st[0])
				found = 1'b1;
		end
	endtask

	// ****************************************
	// Main sequence
	// ****************************************

	initial
	begin
		int          fd;
		int          n;
		int          line_no;
		string       line;
		logic [7:0]  op;
		logic [7:0]  addr;
		logic [31:0] data;
		logic        exp_err;
		logic [31:0] rdata;
		logic        slverr;
		logic        found;

		rvx_port_06 = 1'b0;
		apb_req = '0;
		line_no = 0;
		repeat (5) @(posedge rvx_port_30);
		#1;
		rvx_port_06 = 1'b1;

		fd = $fopen("bench/accel_stimulus.txt", "r");
		if (fd == 0)
		begin
			$display("Could not open the stimulus file bench/accel_stimulus.txt");
			errors++;
		end
		else
		begin
			while (!$feof(fd))
			begin
				n = $fgets(line, fd);
				line_no++;
				if (n == 0 || line.len() == 0 || line.getc(0) == "#")
					continue;
				n = $sscanf(line, "%c %h %h %h", op, addr, data, exp_err);
				if (n != 4)
					continue;
				case (op)
					"W":
					begin
						apb_transfer(1'b1, addr, data, rdata, slverr);
					end
					"R":
					begin
						apb_transfer(1'b0, addr, 32'h0, rdata, slverr);
						// Data of a failed read is not defined
						if (!exp_err)
						begin
							checks++;
							if (rdata !== data)
							begin
								$display("Error: prdata at %h got %h expected %h (line %0d)",
									addr, rdata, data, line_no);
								errors++;
							end
						end
					end
					"P":
					begin
						poll_status(addr, rdata, slverr, found);
						checks++;
						if (!found)
						begin
							$display("Engine did not report done within %0d polls (line %0d)",
								poll_cap, line_no);
							errors++;
						end
						else if (rdata !== data)
						begin
							$display("Error: status got %h expected %h (line %0d)",
								rdata, data, line_no);
							errors++;
						end
					end
					default:
					begin
						$display("Unknown operation in stimulus line %0d", line_no);
						errors++;
						slverr = exp_err;
					end
				endcase
				checks++;
				if (slverr !== exp_err)
				begin
					$display("Error: pslverr at %h got %h expected %h (line %0d)",
						addr, slverr, exp_err, line_no);
					errors++;
				end
			end
			$fclose(fd);
		end

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

//--- bench/accel_stimulus.txt
# op addr value pslverr, all hex; W writes value, R compares read data unless pslverr is 1
# P polls status at addr until done with busy clear, then compares the status value
R 04 00000000 0
R 00 00000000 0
R 18 00000000 0
W 08 000000A6 0
R 08 000000A6 0
# pass-through of two words
W 08 00000000 0
W 0C 12345678 0
W 0C CAFEF00D 0
R 10 00000002 0
W 00 00000001 0
P 04 0000000A 0
R 18 00000002 0
R 14 12345678 0
R 14 CAFEF00D 0
# byte reversal
W 08 00000001 0
W 0C 11223344 0
W 00 00000001 0
P 04 00000006 0
R 14 44332211 0
# inversion
W 08 00000002 0
W 0C 0F0F00FF 0
W 00 00000001 0
P 04 00000006 0
R 14 F0F0FF00 0
# add key 0x3F
W 08 000000FF 0
W 0C FFFFFFF0 0
W 0C 00000100 0
W 00 00000001 0
P 04 0000000A 0
R 14 0000002F 0
R 14 0000013F 0
# fill the transmit FIFO, fifth push fails
W 08 00000001 0
W 0C 00000001 0
W 0C 00000002 0
W 0C 00000003 0
W 0C 00000004 0
W 0C 00000005 1
R 10 00000004 0
R 0C 00000004 0
W 00 00000001 0
P 04 00000012 0
R 18 00000004 0
# back-pressure with the receive FIFO full
W 0C 0A0B0C0D 0
W 0C 11121314 0
W 0C 21222324 0
W 0C 31323334 0
W 00 00000001 0
R 04 00000001 0
W 00 00000001 1
R 04 00000001 0
R 10 00000004 0
R 14 01000000 0
R 14 02000000 0
R 14 03000000 0
R 14 04000000 0
P 04 00000012 0
R 14 0D0C0B0A 0
R 14 14131211 0
R 14 24232221 0
R 14 34333231 0
# bus protocol errors
W 20 00000055 1
R 1C 00000000 1
W 0A 000000AA 1
R 08 00000001 0
W 04 0000001F 1
R 04 00000012 0
W 18 00000007 1
R 14 00000000 1
R 18 00000000 0

//--- compile.f
hdl/mmio_pkg.sv
hdl/word_fifo.sv
hdl/apb_mmio_regs.sv
hdl/transform_engine.sv
hdl/accel_top.sv
bench/tb_accel_top.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_accel_top
FILELIST = compile.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir
